//--- design/rob_entry_store.sv
`timescale 1ns/100ps

module rob_entry_store
  import rob_pkg::*;
(
  input  logic                clk_in,
  input  logic                rst_in,
  // issue side
  input  logic                issue_we,
  input  logic [ITYPE_W-1:0]  issue_itype,
  input  rob_value_u          issue_value,
  input  logic [XLEN-1:0]     issue_dest,
  input  logic [ROB_IX_W-1:0] tail_ix,
  // writeback side
  input  logic                cdb_we,
  input  logic [ROB_IX_W-1:0] cdb_rob_ix,
  input  rob_value_u          cdb_value,
  input  logic [XLEN-1:0]     cdb_dest,
  // retirement side
  input  logic [ROB_IX_W-1:0] head_ix,
  // operand lookups from decode
  input  logic [ROB_IX_W-1:0] lookup_ix1,
  input  logic [ROB_IX_W-1:0] lookup_ix2,
  output logic [ITYPE_W-1:0]  head_itype,
  output rob_value_u          head_value,
  output logic [XLEN-1:0]     head_dest,
  output logic                head_ready,
  output rob_value_u          lookup_value1,
  output logic                lookup_ready1,
  output rob_value_u          lookup_value2,
  output logic                lookup_ready2,
  // branch info for the entry the cdb addresses
  output logic                cdb_is_branch,
  output logic                cdb_pred_taken,
  // arrays for the load hazard check
  output logic [ITYPE_W-1:0]  entry_itype [ROB_SIZE],
  output logic [XLEN-1:0]     entry_dest [ROB_SIZE],
  output logic [ROB_SIZE-1:0] entry_ready
);

  // per-entry fields
  logic [ITYPE_W-1:0]  itype_q [ROB_SIZE];
  rob_value_u          value_q [ROB_SIZE];
  logic [XLEN-1:0]     dest_q [ROB_SIZE];
  logic [ROB_SIZE-1:0] ready_q;
  // class of the entry being written back
  logic [ITYPE_W-1:0]  cdb_itype;
  // base plus offset for stores
  logic [XLEN-1:0]     store_addr;

  assign cdb_itype = itype_q[cdb_rob_ix];
  assign store_addr = dest_q[cdb_rob_ix] + cdb_dest;

  // type and ready bit
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ready_q <= '0;
      for (int i = 0; i < ROB_SIZE; i++) begin
        itype_q[i] <= IT_ALU;
      end
    end else begin
      // fresh entry waits for its result
      if (issue_we) begin
        itype_q[tail_ix] <= issue_itype;
        ready_q[tail_ix] <= 1'b0;
      end
      // every class becomes ready on writeback
      if (cdb_we) begin
        ready_q[cdb_rob_ix] <= 1'b1;
      end
    end
  end

  // value and destination words
  always_ff @(posedge clk_in) begin
    if (issue_we) begin
      value_q[tail_ix] <= issue_value;
      dest_q[tail_ix] <= issue_dest;
    end
    if (cdb_we) begin
      case (cdb_itype)
        // store data plus its computed address
        IT_STORE: begin
          value_q[cdb_rob_ix] <= cdb_value;
          dest_q[cdb_rob_ix] <= store_addr;
        end
        // branch keeps its prediction, outcome goes to recovery
        IT_BRANCH: begin
        end
        default: begin
          value_q[cdb_rob_ix] <= cdb_value;
        end
      endcase
    end
  end

  // head entry for commit
  assign head_itype = itype_q[head_ix];
  assign head_value = value_q[head_ix];
  assign head_dest = dest_q[head_ix];
  assign head_ready = ready_q[head_ix];

  // operand forwarding to decode
  assign lookup_value1 = value_q[lookup_ix1];
  assign lookup_ready1 = ready_q[lookup_ix1];
  assign lookup_value2 = value_q[lookup_ix2];
  assign lookup_ready2 = ready_q[lookup_ix2];

  // prediction stored at issue, read back on writeback
  assign cdb_is_branch = (cdb_itype == IT_BRANCH);
  assign cdb_pred_taken = value_q[cdb_rob_ix].br.predicted_taken;

  assign entry_itype = itype_q;
  assign entry_dest = dest_q;
  assign entry_ready = ready_q;

endmodule

//--- design/rob_load_hazard.sv
`timescale 1ns/100ps

module rob_load_hazard
  import rob_pkg::*;
(
  input  logic [ROB_IX_W-1:0]       head_ix,
  input  logic                      empty,
  input  logic [ITYPE_W-1:0]        entry_itype [ROB_SIZE],
  input  logic [XLEN-1:0]           entry_dest [ROB_SIZE],
  input  logic [ROB_SIZE-1:0]       entry_ready,
  // buffer index and address of each waiting load
  input  logic [ROB_IX_W-1:0]       load_rob_ix [NUM_LOAD_SLOTS],
  input  logic [XLEN-1:0]           load_addr [NUM_LOAD_SLOTS],
  output logic [NUM_LOAD_SLOTS-1:0] can_load
);

  // still between head and the load
  logic                in_range;
  logic [ROB_IX_W-1:0] scan_ix;
  logic                is_store;
  logic                addr_hit;

  always_comb begin
    in_range = 1'b0;
    scan_ix = '0;
    is_store = 1'b0;
    addr_hit = 1'b0;
    for (int s = 0; s < NUM_LOAD_SLOTS; s++) begin
      can_load[s] = 1'b1;
      // nothing older when the buffer is empty
      in_range = !empty;
      // walk oldest first, index wraps by itself
      for (int k = 0; k < ROB_SIZE; k++) begin
        scan_ix = head_ix + ROB_IX_W'(k);
        is_store = (entry_itype[scan_ix] == IT_STORE);
        addr_hit = (entry_dest[scan_ix] == load_addr[s]);
        // unknown address blocks, known address blocks only on a match
        if (in_range && is_store) begin
          if (!entry_ready[scan_ix] || addr_hit) begin
            can_load[s] = 1'b0;
          end
        end
        // stop after the load itself
        if (scan_ix == load_rob_ix[s]) begin
          in_range = 1'b0;
        end
      end
    end
  end

endmodule

//--- design/rob_pkg.sv
package rob_pkg;

  // buffer geometry
  localparam int ROB_SIZE = 8;
  localparam int ROB_IX_W = 3;
  // extra msb tells a full buffer from an empty one
  localparam int ROB_PTR_W = 4;
  // load buffer slots that ask for a hazard check
  localparam int NUM_LOAD_SLOTS = 2;
  localparam int XLEN = 32;
  localparam int ITYPE_W = 4;

  // instruction classes carried in each entry
  localparam logic [ITYPE_W-1:0] IT_ALU = 4'd0;
  localparam logic [ITYPE_W-1:0] IT_LOAD = 4'd1;
  localparam logic [ITYPE_W-1:0] IT_STORE = 4'd2;
  localparam logic [ITYPE_W-1:0] IT_BRANCH = 4'd3;

  // recovery control states
  typedef enum logic {
    ST_RUN = 1'b0,
    ST_FLUSH = 1'b1
  } rec_state_t;

  // entry value word
  // alu/load/store keep a result here,
  // a branch keeps its predicted target and direction
  typedef union packed {
    logic [XLEN-1:0] data;
    struct packed {
      logic [XLEN-2:0] target;
      // lsb, set when predicted taken
      logic predicted_taken;
    } br;
  } rob_value_u;

endpackage

//--- design/rob_pointers.sv
`timescale 1ns/100ps

module rob_pointers
  import rob_pkg::*;
(
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                push,
  input  logic                pop,
  input  logic                mispredict,
  input  logic [ROB_IX_W-1:0] branch_ix,
  output logic [ROB_IX_W-1:0] head_ix,
  output logic [ROB_IX_W-1:0] tail_ix,
  output logic                empty,
  output logic                full,
  output logic [ROB_SIZE-1:0] flush_mask,
  output logic                flush_out
);

  // pointers with wrap bit on top
  logic [ROB_PTR_W-1:0] head_q;
  logic [ROB_PTR_W-1:0] tail_q;
  logic [ROB_PTR_W-1:0] count;
  // full pointer of the mispredicted branch
  logic [ROB_IX_W-1:0]  br_off;
  logic [ROB_PTR_W-1:0] br_ptr;
  // entries younger than the branch
  logic [ROB_PTR_W-1:0] live_after;
  logic [ROB_IX_W-1:0]  first_ix;
  logic [ROB_IX_W-1:0]  rel_ix;
  logic [ROB_SIZE-1:0]  mask_d;
  logic [ROB_SIZE-1:0]  mask_q;
  logic                 flush_q;

  always_comb begin
    count = tail_q - head_q;
    // branch sits between head and tail, so rebuild its wrap bit from head
    br_off = branch_ix - head_q[ROB_IX_W-1:0];
    br_ptr = head_q + ROB_PTR_W'(br_off);
    live_after = tail_q - br_ptr - ROB_PTR_W'(1);
    first_ix = branch_ix + ROB_IX_W'(1);
    // mark slots from branch+1 up to, not including, the old tail
    for (int i = 0; i < ROB_SIZE; i++) begin
      rel_ix = ROB_IX_W'(i) - first_ix;
      mask_d[i] = ROB_PTR_W'(rel_ix) < live_after;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head_q <= '0;
      tail_q <= '0;
      mask_q <= '0;
      flush_q <= 1'b0;
    end else begin
      // retirement goes on during recovery
      if (pop) begin
        head_q <= head_q + ROB_PTR_W'(1);
      end
      // cut the tail back, an issue in the same cycle is dropped
      if (mispredict) begin
        tail_q <= br_ptr + ROB_PTR_W'(1);
      end else if (push) begin
        tail_q <= tail_q + ROB_PTR_W'(1);
      end
      // one-cycle flush pulse with its mask
      flush_q <= mispredict;
      mask_q <= mispredict ? mask_d : '0;
    end
  end

  assign head_ix = head_q[ROB_IX_W-1:0];
  assign tail_ix = tail_q[ROB_IX_W-1:0];
  assign empty = (count == '0);
  assign full = (count == ROB_PTR_W'(ROB_SIZE));
  assign flush_mask = mask_q;
  assign flush_out = flush_q;

endmodule

//--- design/rob_recovery_fsm.sv
`timescale 1ns/100ps

module rob_recovery_fsm
  import rob_pkg::*;
(
  input  logic clk_in,
  input  logic rst_in,
  input  logic cdb_valid,
  // actual outcome, bit 0 of the cdb word
  input  logic cdb_value_bit,
  input  logic cdb_is_branch,
  input  logic cdb_pred_taken,
  output logic mispredict,
  output logic cdb_we,
  output logic issue_block
);

  rec_state_t state_q;
  rec_state_t state_d;
  // branch resolved against its prediction
  logic       wrong_dir;

  assign wrong_dir = cdb_is_branch && (cdb_pred_taken != cdb_value_bit);

  always_comb begin
    state_d = state_q;
    mispredict = 1'b0;
    cdb_we = 1'b0;
    issue_block = 1'b0;
    case (state_q)
      ST_RUN: begin
        // writeback goes straight to the entries
        cdb_we = cdb_valid;
        if (cdb_valid && wrong_dir) begin
          mispredict = 1'b1;
          state_d = ST_FLUSH;
        end
      end
      ST_FLUSH: begin
        // flush cycle, cdb dropped and decode held off
        issue_block = 1'b1;
        state_d = ST_RUN;
      end
      default: begin
        state_d = ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- design/rob_top.sv
`timescale 1ns/100ps

module rob_top
  import rob_pkg::*;
(
  input  logic                      clk_in,
  input  logic                      rst_in,
  // issue from decode
  input  logic                      issue_valid,
  input  logic [ITYPE_W-1:0]        issue_itype,
  input  rob_value_u                issue_value,
  input  logic [XLEN-1:0]           issue_dest,
  // common data bus
  input  logic                      cdb_valid,
  input  logic [ROB_IX_W-1:0]       cdb_rob_ix,
  input  rob_value_u                cdb_value,
  input  logic [XLEN-1:0]           cdb_dest,
  input  logic [ROB_IX_W-1:0]       lookup_ix1,
  input  logic [ROB_IX_W-1:0]       lookup_ix2,
  input  logic [ROB_IX_W-1:0]       load_rob_ix [NUM_LOAD_SLOTS],
  input  logic [XLEN-1:0]           load_addr [NUM_LOAD_SLOTS],
  // store unit took the head store
  input  logic                      store_read,
  output logic                      issue_ready,
  output logic [ROB_IX_W-1:0]       issue_rob_ix,
  // retirement
  output logic                      commit_valid,
  output logic                      store_valid,
  output logic [ROB_IX_W-1:0]       commit_ix,
  output logic [ITYPE_W-1:0]        commit_itype,
  output rob_value_u                commit_value,
  output logic [XLEN-1:0]           commit_dest,
  output rob_value_u                lookup_value1,
  output logic                      lookup_ready1,
  output rob_value_u                lookup_value2,
  output logic                      lookup_ready2,
  output logic [NUM_LOAD_SLOTS-1:0] can_load,
  // branch recovery
  output logic                      flush_out,
  output logic [ROB_SIZE-1:0]       flush_mask
);

  logic                push;
  logic                pop;
  logic                mispredict;
  logic                cdb_we;
  logic                issue_block;
  logic                cdb_value_bit;
  logic                cdb_is_branch;
  logic                cdb_pred_taken;
  logic [ROB_IX_W-1:0] head_ix;
  logic [ROB_IX_W-1:0] tail_ix;
  logic                empty;
  logic                full;
  logic                head_ready;
  logic                head_is_store;
  logic [ITYPE_W-1:0]  entry_itype [ROB_SIZE];
  logic [XLEN-1:0]     entry_dest [ROB_SIZE];
  logic [ROB_SIZE-1:0] entry_ready;

  // space left and not recovering
  assign issue_ready = !full && !issue_block;
  assign push = issue_valid && issue_ready;
  assign issue_rob_ix = tail_ix;
  assign commit_ix = head_ix;
  assign cdb_value_bit = cdb_value.data[0];

  // stores go to the store unit, the rest to the register file
  assign head_is_store = (commit_itype == IT_STORE);
  assign commit_valid = !empty && head_ready && !head_is_store;
  assign store_valid = !empty && head_ready && head_is_store;
  // register file always accepts, store waits for store_read
  assign pop = commit_valid || (store_valid && store_read);

  rob_pointers u_pointers (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .push       (push),
    .pop        (pop),
    .mispredict (mispredict),
    .branch_ix  (cdb_rob_ix),
    .head_ix    (head_ix),
    .tail_ix    (tail_ix),
    .empty      (empty),
    .full       (full),
    .flush_mask (flush_mask),
    .flush_out  (flush_out)
  );

  rob_entry_store u_entry_store (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .issue_we       (push),
    .issue_itype    (issue_itype),
    .issue_value    (issue_value),
    .issue_dest     (issue_dest),
    .tail_ix        (tail_ix),
    .cdb_we         (cdb_we),
    .cdb_rob_ix     (cdb_rob_ix),
    .cdb_value      (cdb_value),
    .cdb_dest       (cdb_dest),
    .head_ix        (head_ix),
    .lookup_ix1     (lookup_ix1),
    .lookup_ix2     (lookup_ix2),
    .head_itype     (commit_itype),
    .head_value     (commit_value),
    .head_dest      (commit_dest),
    .head_ready     (head_ready),
    .lookup_value1  (lookup_value1),
    .lookup_ready1  (lookup_ready1),
    .lookup_value2  (lookup_value2),
    .lookup_ready2  (lookup_ready2),
    .cdb_is_branch  (cdb_is_branch),
    .cdb_pred_taken (cdb_pred_taken),
    .entry_itype    (entry_itype),
    .entry_dest     (entry_dest),
    .entry_ready    (entry_ready)
  );

  rob_load_hazard u_load_hazard (
    .head_ix     (head_ix),
    .empty       (empty),
    .entry_itype (entry_itype),
    .entry_dest  (entry_dest),
    .entry_ready (entry_ready),
    .load_rob_ix (load_rob_ix),
    .load_addr   (load_addr),
    .can_load    (can_load)
  );

  rob_recovery_fsm u_recovery_fsm (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .cdb_valid      (cdb_valid),
    .cdb_value_bit  (cdb_value_bit),
    .cdb_is_branch  (cdb_is_branch),
    .cdb_pred_taken (cdb_pred_taken),
    .mispredict     (mispredict),
    .cdb_we         (cdb_we),
    .issue_block    (issue_block)
  );

endmodule

//--- sources.f
design/rob_pkg.sv
design/rob_pointers.sv
design/rob_entry_store.sv
design/rob_load_hazard.sv
design/rob_recovery_fsm.sv
design/rob_top.sv
verification/tb_rob_top.sv

//--- verification/tb_rob_top.sv
`timescale 1ns/100ps

module tb_rob_top
  import rob_pkg::*;
();

  // run limit in clock cycles
  localparam int MAX_CYCLES = 600;

  logic                      clk_in;
  logic                      rst_in;
  logic                      issue_valid;
  logic [ITYPE_W-1:0]        issue_itype;
  rob_value_u                issue_value;
  logic [XLEN-1:0]           issue_dest;
  logic                      cdb_valid;
  logic [ROB_IX_W-1:0]       cdb_rob_ix;
  rob_value_u                cdb_value;
  logic [XLEN-1:0]           cdb_dest;
  logic [ROB_IX_W-1:0]       lookup_ix1;
  logic [ROB_IX_W-1:0]       lookup_ix2;
  logic [ROB_IX_W-1:0]       load_rob_ix [NUM_LOAD_SLOTS];
  logic [XLEN-1:0]           load_addr [NUM_LOAD_SLOTS];
  logic                      store_read;
  logic                      issue_ready;
  logic [ROB_IX_W-1:0]       issue_rob_ix;
  logic                      commit_valid;
  logic                      store_valid;
  logic [ROB_IX_W-1:0]       commit_ix;
  logic [ITYPE_W-1:0]        commit_itype;
  rob_value_u                commit_value;
  logic [XLEN-1:0]           commit_dest;
  rob_value_u                lookup_value1;
  logic                      lookup_ready1;
  rob_value_u                lookup_value2;
  logic                      lookup_ready2;
  logic [NUM_LOAD_SLOTS-1:0] can_load;
  logic                      flush_out;
  logic [ROB_SIZE-1:0]       flush_mask;

  // reference model holds live entries oldest first
  int                  m_q [$];
  logic [ITYPE_W-1:0]  m_type [ROB_SIZE];
  logic [XLEN-1:0]     m_val [ROB_SIZE];
  logic [XLEN-1:0]     m_dest [ROB_SIZE];
  logic                m_ready [ROB_SIZE];
  logic [ROB_IX_W-1:0] m_tail;
  logic                m_flush;
  logic [ROB_SIZE-1:0] m_mask;

  string  cur_test;
  int     errors;
  int     checks;
  int     tests;
  int     test_err0;
  int     cycles;
  integer seed;

  rob_top uut (.*);

  always #10 clk_in = !clk_in;

  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, test %s never finished", cycles, cur_test);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] got);
    checks++;
    assert (got === exp)
    else begin
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, got);
      errors++;
    end
  endtask

  // flush lasts one cycle only
  assert property (@(posedge clk_in) disable iff (rst_in) flush_out |=> !flush_out)
  else begin
    $display("flush_out held high for two cycles in test %s", cur_test);
    errors++;
  end

  // model steps on every rising edge, sampling what the DUT sees there
  always @(posedge clk_in) begin
    logic exp_cv;
    logic exp_sv;
    logic exp_rdy;
    logic mp;
    int   hix;
    if (!rst_in) begin
      hix = (m_q.size() > 0) ? m_q[0] : 0;
      exp_cv = (m_q.size() > 0) && m_ready[hix] && (m_type[hix] != IT_STORE);
      exp_sv = (m_q.size() > 0) && m_ready[hix] && (m_type[hix] == IT_STORE);
      exp_rdy = (m_q.size() < ROB_SIZE) && !m_flush;
      check_value("commit_valid", exp_cv, commit_valid);
      check_value("store_valid", exp_sv, store_valid);
      check_value("issue_ready", exp_rdy, issue_ready);
      check_value("issue_rob_ix", m_tail, issue_rob_ix);
      check_value("flush_out", m_flush, flush_out);
      check_value("flush_mask", m_flush ? m_mask : '0, flush_mask);
      // retire strictly in issue order
      if (exp_cv || (exp_sv && store_read)) begin
        check_value("commit_ix", hix, commit_ix);
        check_value("commit_itype", m_type[hix], commit_itype);
        check_value("commit_value", m_val[hix], commit_value.data);
        check_value("commit_dest", m_dest[hix], commit_dest);
        void'(m_q.pop_front());
      end
      mp = 1'b0;
      // cdb ignored during the flush cycle
      if (cdb_valid && !m_flush) begin
        if (m_type[cdb_rob_ix] == IT_BRANCH) begin
          mp = (m_val[cdb_rob_ix][0] != cdb_value.data[0]);
        end else if (m_type[cdb_rob_ix] == IT_STORE) begin
          m_val[cdb_rob_ix] = cdb_value.data;
          m_dest[cdb_rob_ix] = m_dest[cdb_rob_ix] + cdb_dest;
        end else begin
          m_val[cdb_rob_ix] = cdb_value.data;
        end
        m_ready[cdb_rob_ix] = 1'b1;
      end
      m_mask = '0;
      if (mp) begin
        // drop everything younger than the branch
        while (m_q.size() > 0 && m_q[m_q.size()-1] != cdb_rob_ix) begin
          m_mask[m_q[m_q.size()-1]] = 1'b1;
          void'(m_q.pop_back());
        end
        m_tail = cdb_rob_ix + 1'b1;
      end else if (issue_valid && exp_rdy) begin
        m_q.push_back(m_tail);
        m_type[m_tail] = issue_itype;
        m_val[m_tail] = issue_value.data;
        m_dest[m_tail] = issue_dest;
        m_ready[m_tail] = 1'b0;
        m_tail = m_tail + 1'b1;
      end
      m_flush = mp;
    end
  end

  // each drive task holds its strobe for one cycle from falling edge to falling edge
  task automatic issue(input logic [ITYPE_W-1:0] itype, input logic [XLEN-1:0] value,
                       input logic [XLEN-1:0] dest);
    issue_valid = 1'b1;
    issue_itype = itype;
    issue_value.data = value;
    issue_dest = dest;
    @(negedge clk_in);
    issue_valid = 1'b0;
  endtask

  task automatic cdb_write(input logic [ROB_IX_W-1:0] ix, input logic [XLEN-1:0] value,
                           input logic [XLEN-1:0] dest);
    cdb_valid = 1'b1;
    cdb_rob_ix = ix;
    cdb_value.data = value;
    cdb_dest = dest;
    @(negedge clk_in);
    cdb_valid = 1'b0;
  endtask

  // store unit always ready while the buffer empties
  task automatic drain();
    store_read = 1'b1;
    while (m_q.size() != 0) begin
      @(negedge clk_in);
    end
    store_read = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s done, %0d errors", cur_test, errors - test_err0);
  endtask

  initial begin
    int                  order [ROB_SIZE];
    int                  j;
    int                  tmp;
    logic [ROB_IX_W-1:0] ix;
    logic [XLEN-1:0]     base;
    logic [XLEN-1:0]     val;
    logic [ROB_SIZE-1:0] exp_mask;
    seed = 32'h66a7;
    errors = 0;
    checks = 0;
    tests = 0;
    cycles = 0;
    cur_test = "reset";
    m_tail = '0;
    m_flush = 1'b0;
    m_mask = '0;
    for (int i = 0; i < ROB_SIZE; i++) begin
      m_type[i] = IT_ALU;
      m_val[i] = '0;
      m_dest[i] = '0;
      m_ready[i] = 1'b0;
    end
    clk_in = 1'b0;
    rst_in = 1'b1;
    issue_valid = 1'b0;
    issue_itype = IT_ALU;
    issue_value = '0;
    issue_dest = '0;
    cdb_valid = 1'b0;
    cdb_rob_ix = '0;
    cdb_value = '0;
    cdb_dest = '0;
    lookup_ix1 = '0;
    lookup_ix2 = '0;
    store_read = 1'b0;
    for (int s = 0; s < NUM_LOAD_SLOTS; s++) begin
      load_rob_ix[s] = '0;
      load_addr[s] = '0;
    end
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;

    // fill all eight slots, then a ninth issue must bounce
    start_test("full");
    ix = issue_rob_ix;
    for (int i = 0; i < ROB_SIZE; i++) begin
      issue(IT_ALU, $random(seed), $random(seed));
    end
    check_value("issue_ready", 0, issue_ready);
    issue(IT_ALU, 32'hdead_beef, 32'h0);
    check_value("issue_rob_ix", ix, issue_rob_ix);
    end_test();

    // complete in shuffled order, retire in issue order
    start_test("in_order");
    for (int i = 0; i < ROB_SIZE; i++) begin
      order[i] = i;
    end
    for (int i = ROB_SIZE - 1; i > 0; i--) begin
      j = $unsigned($random(seed)) % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < ROB_SIZE; i++) begin
      cdb_write(ROB_IX_W'(ix + order[i]), $random(seed), '0);
    end
    drain();
    end_test();

    // younger alu is ready first but waits behind the store
    start_test("store");
    base = $random(seed);
    ix = issue_rob_ix;
    issue(IT_STORE, 32'h0, base);
    issue(IT_ALU, 32'h0, 32'h11);
    cdb_write(ROB_IX_W'(ix + 1), $random(seed), '0);
    cdb_write(ix, $random(seed), 32'h40);
    repeat (3) begin
      @(negedge clk_in);
      check_value("store_valid", 1, store_valid);
      check_value("commit_ix", ix, commit_ix);
      check_value("commit_dest", base + 32'h40, commit_dest);
    end
    store_read = 1'b1;
    @(negedge clk_in);
    store_read = 1'b0;
    drain();
    end_test();

    // two loads, each lookup port watches its own entry
    start_test("lookup");
    ix = issue_rob_ix;
    lookup_ix1 = ix;
    lookup_ix2 = ROB_IX_W'(ix + 1);
    issue(IT_LOAD, 32'h0, 32'h5);
    issue(IT_LOAD, 32'h0, 32'h6);
    check_value("lookup_ready1", 0, lookup_ready1);
    check_value("lookup_ready2", 0, lookup_ready2);
    val = $random(seed);
    cdb_write(ix, val, '0);
    check_value("lookup_ready1", 1, lookup_ready1);
    check_value("lookup_value1", val, lookup_value1.data);
    check_value("lookup_ready2 before write", 0, lookup_ready2);
    val = $random(seed);
    cdb_write(ROB_IX_W'(ix + 1), val, '0);
    check_value("lookup_ready2", 1, lookup_ready2);
    check_value("lookup_value2", val, lookup_value2.data);
    drain();
    end_test();

    // slot 0 waits behind a store and slot 1 only behind an alu
    start_test("load_hazard");
    ix = issue_rob_ix;
    base = $random(seed);
    load_rob_ix[0] = ROB_IX_W'(ix + 2);
    load_addr[0] = base + 32'h8;
    load_rob_ix[1] = ix;
    load_addr[1] = base + 32'h8;
    issue(IT_ALU, 32'h0, 32'h1);
    issue(IT_STORE, 32'h0, base);
    issue(IT_LOAD, 32'h0, 32'h2);
    check_value("can_load[0] unready store", 0, can_load[0]);
    check_value("can_load[1] no store", 1, can_load[1]);
    cdb_write(ROB_IX_W'(ix + 1), $random(seed), 32'h8);
    check_value("can_load[0] same address", 0, can_load[0]);
    load_addr[0] = base + 32'hc;
    @(negedge clk_in);
    check_value("can_load[0] other address", 1, can_load[0]);
    cdb_write(ix, $random(seed), '0);
    cdb_write(ROB_IX_W'(ix + 2), $random(seed), '0);
    drain();
    end_test();

    // branch predicted taken resolves not taken
    start_test("mispredict");
    ix = issue_rob_ix;
    issue(IT_ALU, 32'h0, 32'h3);
    issue(IT_BRANCH, 32'h0000_1001, 32'h0);
    issue(IT_ALU, 32'h0, 32'h4);
    issue(IT_ALU, 32'h0, 32'h5);
    exp_mask = '0;
    exp_mask[ROB_IX_W'(ix + 2)] = 1'b1;
    exp_mask[ROB_IX_W'(ix + 3)] = 1'b1;
    cdb_write(ROB_IX_W'(ix + 1), 32'h0, '0);
    check_value("flush_out", 1, flush_out);
    check_value("flush_mask", exp_mask, flush_mask);
    check_value("issue_rob_ix", ROB_IX_W'(ix + 2), issue_rob_ix);
    @(negedge clk_in);
    check_value("flush_out after pulse", 0, flush_out);
    // not-taken prediction that holds
    issue(IT_BRANCH, 32'h0000_2000, 32'h0);
    cdb_write(ROB_IX_W'(ix + 2), 32'h0, '0);
    check_value("flush_out good branch", 0, flush_out);
    cdb_write(ix, $random(seed), '0);
    drain();
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
